// ==== logic/pattern_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "vga_settings.svh"

module pattern_gen
(
    input  logic              clk,
    input  logic              rst_n,
    input  vga_pkg::coord_x_t x,
    input  vga_pkg::coord_y_t y,
    input  logic              display_on,
    input  logic              hsync_raw,
    input  logic              vsync_raw,
    input  vga_pkg::wb_dat_t  ctrl,
    input  vga_pkg::offset_t  dx,
    input  vga_pkg::offset_t  dy,
    output vga_pkg::color_t   red,
    output vga_pkg::color_t   green,
    output vga_pkg::color_t   blue,
    output logic              hsync,
    output logic              vsync
);

    import vga_pkg::*;

    // Rectangle bounds with exclusive upper ends
    localparam coord_x_t rect_x_lo = coord_x_t'(`SCREEN_WIDTH / 2);
    localparam coord_x_t rect_x_hi = coord_x_t'(`SCREEN_WIDTH * 2 / 3 + 1);
    localparam coord_y_t rect_y_lo = coord_y_t'(`SCREEN_HEIGHT / 2);
    localparam coord_y_t rect_y_hi = coord_y_t'(`SCREEN_HEIGHT * 2 / 3);

    // Ellipse limit is the square of half the screen width
    localparam logic [2 * `W_X + 1:0] radius_sq = (`SCREEN_WIDTH / 2) * (`SCREEN_WIDTH / 2);

    logic [2 * `W_X - 1:0] x_sq;
    logic [2 * `W_X - 1:0] y_sq;
    logic [2 * `W_X + 1:0] ellipse;
    color_t                xc;
    color_t                yc;
    color_t                s_red;
    color_t                s_green;
    color_t                s_blue;
    color_t                d_red;
    color_t                d_green;
    color_t                d_blue;

    //----------------------------------------
    // Static pattern

    assign x_sq    = x * x;
    assign y_sq    = y * y;
    // x^2 + 2y^2
    assign ellipse = {2'b00, x_sq} + {1'b0, y_sq, 1'b0};

    // Later shapes overwrite only their own channel
    always_comb
    begin
        s_red   = '0;
        s_green = '0;
        s_blue  = '0;
        if (x >= rect_x_lo && x < rect_x_hi && y >= rect_y_lo && y < rect_y_hi)
            s_green = x[`W_X - 2 -: `W_COLOR];
        if (ellipse < radius_sq)
            s_red = x[`W_X - 2 -: `W_COLOR];
        // Parabola below y = x^2 / 1024
        if (x_sq[`W_X +: `W_Y] < y)
            s_blue = y[`W_Y - 1 -: `W_COLOR];
    end

    //----------------------------------------
    // Dynamic pattern

    assign xc = x[`W_X - 2 -: `W_COLOR];
    assign yc = y[`W_Y - 2 -: `W_COLOR];

    // Sums wrap at the channel width
    assign d_red   = xc + xc + yc + dx[`W_COLOR - 1:0];
    assign d_green = xc - yc - dy[`W_COLOR - 1:0];
    assign d_blue  = {`W_COLOR{ctrl[CTRL_BLUE_FILL]}};

    // Output stage with the syncs delayed to match the colours
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end
        else
        begin
            hsync <= hsync_raw;
            vsync <= vsync_raw;
            if (!display_on)
            begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
            else if (ctrl[CTRL_DYNAMIC])
            begin
                red   <= d_red;
                green <= d_green;
                blue  <= d_blue;
            end
            else
            begin
                red   <= s_red;
                green <= s_green;
                blue  <= s_blue;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pattern_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_regs
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  vga_pkg::wb_adr_t wb_adr,
    input  vga_pkg::wb_dat_t wb_dat_i,
    output vga_pkg::wb_dat_t wb_dat_o,
    output logic             wb_ack,
    input  logic             strobe,
    output vga_pkg::wb_dat_t ctrl,
    output vga_pkg::offset_t dx,
    output vga_pkg::offset_t dy
);

    import vga_pkg::*;

    logic    stb_seen;
    logic    wr_en;
    offset_t dx_step;
    offset_t dy_step;

    //----------------------------------------
    // Bus handshake

    // Set one cycle after the strobe appears, cleared by the ack
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            stb_seen <= 1'b0;
        else
            stb_seen <= wb_cyc & wb_stb & ~wb_ack;
    end

    // Ack lasts a single cycle
    assign wb_ack = stb_seen & wb_cyc & wb_stb;
    // Writes land on the ack edge
    assign wr_en  = wb_ack & wb_we;

    //----------------------------------------
    // Registers

    // Control and step values
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ctrl    <= '0;
            dx_step <= '0;
            dy_step <= '0;
        end
        else if (wr_en)
        begin
            case (wb_adr)
                REG_CTRL:    ctrl    <= wb_dat_i;
                REG_DX_STEP: dx_step <= wb_dat_i;
                REG_DY_STEP: dy_step <= wb_dat_i;
                default:     ;
            endcase
        end
    end

    // Offset accumulators, host write beats the strobe step
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            dx <= '0;
            dy <= '0;
        end
        else
        begin
            if (wr_en && wb_adr == REG_DX)
                dx <= wb_dat_i;
            else if (strobe)
                dx <= dx + dx_step;

            if (wr_en && wb_adr == REG_DY)
                dy <= wb_dat_i;
            else if (strobe)
                dy <= dy + dy_step;
        end
    end

    // Read mux, zero on unused addresses
    always_comb
    begin
        case (wb_adr)
            REG_CTRL:    wb_dat_o = ctrl;
            REG_DX_STEP: wb_dat_o = dx_step;
            REG_DY_STEP: wb_dat_o = dy_step;
            REG_DX:      wb_dat_o = dx;
            REG_DY:      wb_dat_o = dy;
            default:     wb_dat_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/strobe_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module strobe_gen
#(
    parameter int clk_mhz   = 25,
    parameter int strobe_hz = 10
)
(
    input  logic clk,
    input  logic rst_n,
    output logic strobe
);

    // Clocks per strobe period
    localparam int ratio = clk_mhz * 1000000 / strobe_hz;
    localparam int w_cnt = (ratio > 1) ? $clog2(ratio) : 1;

    logic [w_cnt - 1:0] cnt;

    // Down-counter, reload on reaching zero
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            cnt <= '0;
        else if (cnt == '0)
            cnt <= w_cnt'(ratio - 1);
        else
            cnt <= cnt - 1'b1;
    end

    // One cycle high per period
    assign strobe = (cnt == '0);

endmodule

`default_nettype wire

// ==== logic/vga_pattern_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_pattern_top
#(
    parameter int clk_mhz   = 25,
    parameter int strobe_hz = 10
)
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  vga_pkg::wb_adr_t wb_adr,
    input  vga_pkg::wb_dat_t wb_dat_i,
    output vga_pkg::wb_dat_t wb_dat_o,
    output logic             wb_ack,
    output vga_pkg::color_t  red,
    output vga_pkg::color_t  green,
    output vga_pkg::color_t  blue,
    output logic             hsync,
    output logic             vsync
);

    import vga_pkg::*;

    // Raster position and raw syncs
    coord_x_t x;
    coord_y_t y;
    logic     display_on;
    logic     hsync_raw;
    logic     vsync_raw;

    // Motion tick and pattern setup
    logic     strobe;
    wb_dat_t  ctrl;
    offset_t  dx;
    offset_t  dy;

    vga_timing i_timing
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .x          (x),
        .y          (y),
        .display_on (display_on),
        .hsync_raw  (hsync_raw),
        .vsync_raw  (vsync_raw)
    );

    strobe_gen #(.clk_mhz (clk_mhz), .strobe_hz (strobe_hz)) i_strobe_gen
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .strobe (strobe)
    );

    pattern_regs i_regs
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .strobe   (strobe),
        .ctrl     (ctrl),
        .dx       (dx),
        .dy       (dy)
    );

    // One clock from coordinate to pixel
    pattern_gen i_pattern
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .x          (x),
        .y          (y),
        .display_on (display_on),
        .hsync_raw  (hsync_raw),
        .vsync_raw  (vsync_raw),
        .ctrl       (ctrl),
        .dx         (dx),
        .dy         (dy),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .hsync      (hsync),
        .vsync      (vsync)
    );

endmodule

`default_nettype wire

// ==== logic/vga_pkg.sv ====
`default_nettype none
`include "vga_settings.svh"

package vga_pkg;

    // Counters and coordinates
    typedef logic [`W_X - 1:0]      coord_x_t;
    // One extra bit so the full frame count of 525 fits
    typedef logic [`W_Y:0]          coord_y_t;
    typedef logic [`W_COLOR - 1:0]  color_t;

    // Register bus
    typedef logic [`WB_ADR_W - 1:0] wb_adr_t;
    typedef logic [`WB_DAT_W - 1:0] wb_dat_t;
    typedef logic [7:0]             offset_t;

    // Register map
    localparam wb_adr_t REG_CTRL    = 3'd0;
    localparam wb_adr_t REG_DX_STEP = 3'd1;
    localparam wb_adr_t REG_DY_STEP = 3'd2;
    localparam wb_adr_t REG_DX      = 3'd3;
    localparam wb_adr_t REG_DY      = 3'd4;

    // Control register bits
    localparam int CTRL_DYNAMIC   = 0;
    localparam int CTRL_BLUE_FILL = 1;

endpackage

`default_nettype wire

// ==== logic/vga_settings.svh ====
`ifndef VGA_SETTINGS_SVH
`define VGA_SETTINGS_SVH

// Visible area in pixels
`define SCREEN_WIDTH   640
`define SCREEN_HEIGHT  480

// Horizontal timing in pixel clocks
`define H_FRONT        16
`define H_SYNC         96
`define H_BACK         48

// Vertical timing in lines
`define V_FRONT        10
`define V_SYNC         2
`define V_BACK         33

// Coordinate widths of the visible area
`define W_X            10
`define W_Y            9

// One colour channel
`define W_COLOR        4

// Register bus widths
`define WB_ADR_W       3
`define WB_DAT_W       8

`endif

// ==== logic/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "vga_settings.svh"

module vga_timing
(
    input  logic              clk,
    input  logic              rst_n,
    output vga_pkg::coord_x_t x,
    output vga_pkg::coord_y_t y,
    output logic              display_on,
    output logic              hsync_raw,
    output logic              vsync_raw
);

    import vga_pkg::*;

    // Line and frame lengths
    localparam int h_total = `SCREEN_WIDTH + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int v_total = `SCREEN_HEIGHT + `V_FRONT + `V_SYNC + `V_BACK;

    // Sync windows, first count and one past the last
    localparam coord_x_t h_sync_lo = coord_x_t'(`SCREEN_WIDTH + `H_FRONT);
    localparam coord_x_t h_sync_hi = coord_x_t'(`SCREEN_WIDTH + `H_FRONT + `H_SYNC);
    localparam coord_y_t v_sync_lo = coord_y_t'(`SCREEN_HEIGHT + `V_FRONT);
    localparam coord_y_t v_sync_hi = coord_y_t'(`SCREEN_HEIGHT + `V_FRONT + `V_SYNC);

    coord_x_t h_cnt;
    coord_y_t v_cnt;
    logic     h_last;
    logic     v_last;

    assign h_last = (h_cnt == coord_x_t'(h_total - 1));
    assign v_last = (v_cnt == coord_y_t'(v_total - 1));

    //----------------------------------------
    // Counters

    // Pixel count within the line
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            h_cnt <= '0;
        else if (h_last)
            h_cnt <= '0;
        else
            h_cnt <= h_cnt + 1'b1;
    end

    // Line count, steps once per line wrap
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            v_cnt <= '0;
        else if (h_last)
        begin
            if (v_last)
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end
    end

    //----------------------------------------
    // Decode

    assign x = h_cnt;
    assign y = v_cnt;

    assign display_on = (h_cnt < coord_x_t'(`SCREEN_WIDTH))
                      & (v_cnt < coord_y_t'(`SCREEN_HEIGHT));

    // Both syncs active low
    assign hsync_raw = ~((h_cnt >= h_sync_lo) & (h_cnt < h_sync_hi));
    assign vsync_raw = ~((v_cnt >= v_sync_lo) & (v_cnt < v_sync_hi));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the VGA pattern testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_vga_pattern_top \
    -f vga_pattern_top.f \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== test/tb_vga_pattern_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vga_pattern_top;

    import vga_pkg::*;

    localparam int clk_period   = 40;
    localparam int line_cycles  = 800;
    localparam int frame_lines  = 525;
    localparam int frame_cycles = line_cycles * frame_lines;
    // Three frames of pattern checks plus slack for the bus tests
    localparam int timeout_cycles = 3 * frame_cycles + 50 * line_cycles;

    logic    clk;
    logic    rst_n;
    logic    wb_cyc;
    logic    wb_stb;
    logic    wb_we;
    wb_adr_t wb_adr;
    wb_dat_t wb_dat_i;
    wb_dat_t wb_dat_o;
    logic    wb_ack;
    color_t  red;
    color_t  green;
    color_t  blue;
    logic    hsync;
    logic    vsync;

    // Bookkeeping
    int cyc_cnt      = 0;
    int ack_count    = 0;
    int err_count    = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    // Reference raster and expected outputs
    int         h_m;
    int         v_m;
    int         exp_x;
    int         exp_y;
    int         exp_red;
    int         exp_green;
    int         exp_blue;
    int         exp_hs;
    int         exp_vs;
    logic [7:0] m_ctrl = '0;
    int         m_dx   = 0;
    int         m_dy   = 0;

    // Strobe every 100 clocks
    vga_pattern_top #(.clk_mhz (25), .strobe_hz (250000)) i_dut
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .hsync    (hsync),
        .vsync    (vsync)
    );

    always #(clk_period / 2) clk = ~clk;

    //----------------------------------------
    // Reference model

    // Colour of one pixel from the pattern rules
    task automatic predict_pixel(input int x, input int y, output int r, output int g,
                                 output int b);
        int xc;
        int yc;
        r = 0;
        g = 0;
        b = 0;
        if (x < 640 && y < 480)
        begin
            if (m_ctrl[CTRL_DYNAMIC])
            begin
                xc = (x >> 5) & 15;
                yc = (y >> 4) & 15;
                r  = (xc + xc + yc + m_dx) & 15;
                g  = (xc - yc - m_dy) & 15;
                b  = m_ctrl[CTRL_BLUE_FILL] ? 15 : 0;
            end
            else
            begin
                // Rectangle with inclusive bounds
                if (x >= 320 && x <= 426 && y >= 240 && y <= 319)
                    g = (x >> 5) & 15;
                if (x * x + 2 * y * y < 320 * 320)
                    r = (x >> 5) & 15;
                // Parabola
                if ((((x * x) >> 10) & 511) < y)
                    b = (y >> 5) & 15;
            end
        end
    endtask

    // Own counters that predict the outputs of the next cycle
    always @(posedge clk)
    begin : model
        int r;
        int g;
        int b;
        cyc_cnt <= cyc_cnt + 1;
        if (!rst_n)
        begin
            h_m       <= 0;
            v_m       <= 0;
            exp_x     <= 0;
            exp_y     <= 0;
            exp_red   <= 0;
            exp_green <= 0;
            exp_blue  <= 0;
            exp_hs    <= 1;
            exp_vs    <= 1;
        end
        else
        begin
            predict_pixel(h_m, v_m, r, g, b);
            exp_x     <= h_m;
            exp_y     <= v_m;
            exp_red   <= r;
            exp_green <= g;
            exp_blue  <= b;
            exp_hs    <= (h_m >= 656 && h_m <= 751) ? 0 : 1;
            exp_vs    <= (v_m >= 490 && v_m <= 491) ? 0 : 1;
            if (h_m == line_cycles - 1)
            begin
                h_m <= 0;
                v_m <= (v_m == frame_lines - 1) ? 0 : v_m + 1;
            end
            else
                h_m <= h_m + 1;
        end
    end

    // Acks counted away from the clock edge
    always @(negedge clk)
    begin
        if (wb_ack)
            ack_count <= ack_count + 1;
    end

    //----------------------------------------
    // Helpers

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected)
        begin
            err_count++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
        end
    endtask

    // One classic cycle with stamp taken as the cycle count at the request edge
    task automatic wishbone_access(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                                   output wb_dat_t rdat, output int stamp);
        int waited;
        int acks_before;
        @(posedge clk);
        stamp       = cyc_cnt;
        acks_before = ack_count;
        rdat        = '0;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_i <= wdat;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
        end
        while (!wb_ack && waited < 4);
        if (!wb_ack)
        begin
            err_count++;
            $display("Wishbone acknowledge missing for 4 cycles at address %0d", adr);
        end
        else
        begin
            rdat = wb_dat_o;
            compare_value("wb_ack latency", waited, 2);
        end
        // Master lets go in the ack cycle
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        compare_value("wb_ack cycles", ack_count - acks_before, 1);
    endtask

    task automatic write_reg(input wb_adr_t adr, input wb_dat_t dat);
        wb_dat_t unused;
        int      stamp;
        wishbone_access(1'b1, adr, dat, unused, stamp);
    endtask

    task automatic read_reg(input wb_adr_t adr, output wb_dat_t dat, output int stamp);
        wishbone_access(1'b0, adr, '0, dat, stamp);
    endtask

    function automatic logic sync_level(input bit vertical);
        return vertical ? vsync : hsync;
    endfunction

    // Returns at the first low sample after a high one
    task automatic find_sync_fall(input bit vertical, output int stamp);
        logic prev;
        prev = sync_level(vertical);
        @(negedge clk);
        while (!(prev && !sync_level(vertical)))
        begin
            prev = sync_level(vertical);
            @(negedge clk);
        end
        stamp = cyc_cnt;
    endtask

    task automatic count_sync_low(input bit vertical, output int len);
        len = 0;
        while (!sync_level(vertical))
        begin
            len++;
            @(negedge clk);
        end
    endtask

    // Any full frame period covers every coordinate once
    task automatic check_frame();
        int n;
        for (n = 0; n < frame_cycles; n++)
        begin
            @(negedge clk);
            compare_value("red", red, exp_red);
            compare_value("green", green, exp_green);
            compare_value("blue", blue, exp_blue);
            compare_value("hsync", hsync, exp_hs);
            compare_value("vsync", vsync, exp_vs);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            tests_passed++;
            $display("Test %s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    //----------------------------------------
    // Tests

    initial
    begin : stimulus
        int      errs;
        int      t1;
        int      t2;
        int      len;
        int      sx;
        int      sy;
        int      step_x;
        int      step_y;
        wb_dat_t rd;
        wb_dat_t v_ctrl;
        wb_dat_t v_xs;
        wb_dat_t v_ys;
        wb_dat_t dx1;
        wb_dat_t dy1;
        wb_dat_t dx2;
        wb_dat_t dy2;
        void'($urandom(32'hfa75));
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        // Reset values and then sync shapes
        errs = err_count;
        compare_value("hsync", hsync, 1);
        compare_value("vsync", vsync, 1);
        compare_value("red", red, 0);
        compare_value("green", green, 0);
        compare_value("blue", blue, 0);
        find_sync_fall(1'b0, t1);
        count_sync_low(1'b0, len);
        compare_value("hsync low length", len, 96);
        find_sync_fall(1'b0, t2);
        compare_value("hsync period", t2 - t1, line_cycles);
        find_sync_fall(1'b1, t1);
        compare_value("vsync fall line", exp_y, 490);
        compare_value("vsync fall pixel", exp_x, 0);
        count_sync_low(1'b1, len);
        compare_value("vsync low length", len, 2 * line_cycles);
        report_test("reset and sync timing", errs);

        // Register readback
        errs   = err_count;
        v_ctrl = wb_dat_t'($urandom);
        v_xs   = wb_dat_t'($urandom);
        v_ys   = wb_dat_t'($urandom);
        write_reg(REG_CTRL, v_ctrl);
        write_reg(REG_DX_STEP, v_xs);
        write_reg(REG_DY_STEP, v_ys);
        m_ctrl = v_ctrl;
        read_reg(REG_CTRL, rd, sx);
        compare_value("ctrl", rd, v_ctrl);
        read_reg(REG_DX_STEP, rd, sx);
        compare_value("dx_step", rd, v_xs);
        read_reg(REG_DY_STEP, rd, sx);
        compare_value("dy_step", rd, v_ys);
        read_reg(wb_adr_t'(5 + $urandom % 3), rd, sx);
        compare_value("unused register", rd, 0);
        report_test("register access", errs);

        // Static pattern over one frame
        errs = err_count;
        write_reg(REG_CTRL, 8'h00);
        m_ctrl = 8'h00;
        check_frame();
        report_test("static pattern", errs);

        // Dynamic pattern with fixed offsets
        errs = err_count;
        write_reg(REG_DX_STEP, 8'h00);
        write_reg(REG_DY_STEP, 8'h00);
        m_dx = $urandom % 256;
        m_dy = $urandom % 256;
        write_reg(REG_DX, wb_dat_t'(m_dx));
        write_reg(REG_DY, wb_dat_t'(m_dy));
        v_ctrl = {6'b0, 1'($urandom % 2), 1'b1};
        write_reg(REG_CTRL, v_ctrl);
        m_ctrl = v_ctrl;
        check_frame();
        report_test("dynamic pattern", errs);

        // Offsets after ten strobe periods
        errs   = err_count;
        step_x = 1 + $urandom % 255;
        step_y = 1 + $urandom % 255;
        write_reg(REG_DX_STEP, wb_dat_t'(step_x));
        write_reg(REG_DY_STEP, wb_dat_t'(step_y));
        read_reg(REG_DX, dx1, sx);
        read_reg(REG_DY, dy1, sy);
        while (cyc_cnt != sx + 1000)
            @(negedge clk);
        read_reg(REG_DX, dx2, t1);
        while (cyc_cnt != sy + 1000)
            @(negedge clk);
        read_reg(REG_DY, dy2, t2);
        compare_value("dx advance", wb_dat_t'(dx2 - dx1), (10 * step_x) & 255);
        compare_value("dy advance", wb_dat_t'(dy2 - dy1), (10 * step_y) & 255);
        report_test("offset stepping", errs);

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (err_count == 0 && tests_failed == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(timeout_cycles * clk_period);
        $display("Watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vga_pattern_top.f ====
+incdir+logic
logic/vga_pkg.sv
logic/vga_timing.sv
logic/strobe_gen.sv
logic/pattern_regs.sv
logic/pattern_gen.sv
logic/vga_pattern_top.sv
test/tb_vga_pattern_top.sv
